//--- axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

   // Native and AXI widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // AXI burst length and response fields
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_RESP_W = 2;

   // Anything other than OKAY is treated as a failed transfer
   localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;

   // Burst engine states, the read engine never enters ST_RESP
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;
   localparam logic [1:0] ST_RESP = 2'd3;

endpackage

`default_nettype wire

//--- build.f
axi_bridge_pkg.sv
iob2axi_rd.sv
iob2axi_wr.sv
iob2axi.sv
tb_axi_mem.sv
tb_iob2axi.sv

//--- iob2axi.sv
`default_nettype none

module iob2axi
   import axi_bridge_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,

   // Control
   input  wire  [AXI_LEN_W-1:0]  length,
   output logic                  iob2axi_ready,
   output logic                  error,

   // Native side
   input  wire                   valid,
   input  wire  [ADDR_W-1:0]     addr,
   input  wire  [DATA_W-1:0]     wdata,
   input  wire  [DATA_W/8-1:0]   wstrb,
   output logic [DATA_W-1:0]     rdata,
   output logic                  ready,

   // AXI master, read channels
   output logic [ADDR_W-1:0]     m_araddr,
   output logic [AXI_LEN_W-1:0]  m_arlen,
   output logic                  m_arvalid,
   input  wire                   m_arready,
   input  wire  [DATA_W-1:0]     m_rdata,
   input  wire  [AXI_RESP_W-1:0] m_rresp,
   input  wire                   m_rlast,
   input  wire                   m_rvalid,
   output logic                  m_rready,

   // AXI master, write channels
   output logic [ADDR_W-1:0]     m_awaddr,
   output logic [AXI_LEN_W-1:0]  m_awlen,
   output logic                  m_awvalid,
   input  wire                   m_awready,
   output logic [DATA_W-1:0]     m_wdata,
   output logic [DATA_W/8-1:0]   m_wstrb,
   output logic                  m_wlast,
   output logic                  m_wvalid,
   input  wire                   m_wready,
   input  wire  [AXI_RESP_W-1:0] m_bresp,
   input  wire                   m_bvalid,
   output logic                  m_bready
);

   logic is_write;
   logic rd_valid;
   logic wr_valid;
   logic rd_ack;
   logic wr_ack;
   logic rd_idle;
   logic wr_idle;
   logic rd_error;
   logic wr_error;
   logic last_write;

   // Any strobe set marks a write
   assign is_write = |wstrb;
   assign rd_valid = valid && !is_write;
   assign wr_valid = valid && is_write;

   assign ready         = is_write ? wr_ack : rd_ack;
   assign iob2axi_ready = rd_idle && wr_idle;
   assign error         = last_write ? wr_error : rd_error;

   // Engine that opened the latest burst owns the error status
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_write <= 1'b0;
      end else if (valid && (is_write ? wr_idle : rd_idle)) begin
         last_write <= is_write;
      end
   end

   iob2axi_rd u_rd (
      .clk       (clk),
      .rst_n     (rst_n),
      .length    (length),
      .rd_ready  (rd_idle),
      .error     (rd_error),
      .valid     (rd_valid),
      .addr      (addr),
      .rdata     (rdata),
      .ready     (rd_ack),
      .m_araddr  (m_araddr),
      .m_arlen   (m_arlen),
      .m_arvalid (m_arvalid),
      .m_arready (m_arready),
      .m_rdata   (m_rdata),
      .m_rresp   (m_rresp),
      .m_rlast   (m_rlast),
      .m_rvalid  (m_rvalid),
      .m_rready  (m_rready)
   );

   iob2axi_wr u_wr (
      .clk       (clk),
      .rst_n     (rst_n),
      .length    (length),
      .wr_ready  (wr_idle),
      .error     (wr_error),
      .valid     (wr_valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .ready     (wr_ack),
      .m_awaddr  (m_awaddr),
      .m_awlen   (m_awlen),
      .m_awvalid (m_awvalid),
      .m_awready (m_awready),
      .m_wdata   (m_wdata),
      .m_wstrb   (m_wstrb),
      .m_wlast   (m_wlast),
      .m_wvalid  (m_wvalid),
      .m_wready  (m_wready),
      .m_bresp   (m_bresp),
      .m_bvalid  (m_bvalid),
      .m_bready  (m_bready)
   );

endmodule

`default_nettype wire

//--- iob2axi_rd.sv
`default_nettype none

module iob2axi_rd
   import axi_bridge_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,

   // Control
   input  wire  [AXI_LEN_W-1:0]  length,
   output logic                  rd_ready,
   output logic                  error,

   // Native side
   input  wire                   valid,
   input  wire  [ADDR_W-1:0]     addr,
   output logic [DATA_W-1:0]     rdata,
   output logic                  ready,

   // AR channel
   output logic [ADDR_W-1:0]     m_araddr,
   output logic [AXI_LEN_W-1:0]  m_arlen,
   output logic                  m_arvalid,
   input  wire                   m_arready,

   // R channel
   input  wire  [DATA_W-1:0]     m_rdata,
   input  wire  [AXI_RESP_W-1:0] m_rresp,
   input  wire                   m_rlast,
   input  wire                   m_rvalid,
   output logic                  m_rready
);

   logic [1:0]           state;
   logic [ADDR_W-1:0]    addr_q;
   logic [AXI_LEN_W-1:0] len_q;
   logic [AXI_LEN_W-1:0] beat_cnt;
   logic                 open;
   logic                 r_xfer;
   logic                 last_due;

   // First request while idle opens the burst without taking the word
   assign open     = (state == ST_IDLE) && valid;
   assign r_xfer   = m_rvalid && m_rready;
   assign last_due = (beat_cnt == len_q);

   assign rd_ready  = (state == ST_IDLE);
   assign m_arvalid = (state == ST_ADDR);
   assign m_araddr  = addr_q;
   assign m_arlen   = len_q;

   // Beats pass straight through without buffering
   assign m_rready = (state == ST_DATA) && valid;
   assign ready    = m_rready && m_rvalid;
   assign rdata    = m_rdata;

   // Burst address and length
   always_ff @(posedge clk) begin
      if (open) begin
         addr_q <= addr;
         len_q  <= length;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         beat_cnt <= '0;
         error    <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (open) begin
                  state    <= ST_ADDR;
                  beat_cnt <= '0;
                  error    <= 1'b0;
               end
            end
            ST_ADDR: begin
               if (m_arready) begin
                  state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (r_xfer) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  // Bad response or rlast out of step with the count
                  if (m_rresp != RESP_OKAY || m_rlast != last_due) begin
                     error <= 1'b1;
                  end
                  if (m_rlast) begin
                     state <= ST_IDLE;
                  end
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // AR request is held with stable payload until accepted
   a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
      m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen));

endmodule

`default_nettype wire

//--- iob2axi_vectors.txt
# op addr len seed step err, all fields hex
# op is W for write or R for read, err is 1 when an AXI error response is due
W 00000000 00 11111111 00000001 0
R 00000000 00 11111111 00000001 0
W 00000100 0f a5a50000 00000101 0
R 00000100 0f a5a50000 00000101 0
W 00008200 03 deadbeef 00000010 1
R 00000100 0f a5a50000 00000101 0
R 00008040 07 00000000 00000000 1
R 00000000 00 11111111 00000001 0
W 00000200 07 0badf00d 11111111 0
R 00000200 07 0badf00d 11111111 0
W 00000400 0f 80000000 ffffffff 0
R 00000400 0f 80000000 ffffffff 0
W 00008300 0f 12345678 00000001 1
W 00000300 01 00000000 00000004 0
R 00000300 01 00000000 00000004 0

//--- iob2axi_wr.sv
`default_nettype none

module iob2axi_wr
   import axi_bridge_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,

   // Control
   input  wire  [AXI_LEN_W-1:0]  length,
   output logic                  wr_ready,
   output logic                  error,

   // Native side
   input  wire                   valid,
   input  wire  [ADDR_W-1:0]     addr,
   input  wire  [DATA_W-1:0]     wdata,
   input  wire  [DATA_W/8-1:0]   wstrb,
   output logic                  ready,

   // AW channel
   output logic [ADDR_W-1:0]     m_awaddr,
   output logic [AXI_LEN_W-1:0]  m_awlen,
   output logic                  m_awvalid,
   input  wire                   m_awready,

   // W channel
   output logic [DATA_W-1:0]     m_wdata,
   output logic [DATA_W/8-1:0]   m_wstrb,
   output logic                  m_wlast,
   output logic                  m_wvalid,
   input  wire                   m_wready,

   // B channel
   input  wire  [AXI_RESP_W-1:0] m_bresp,
   input  wire                   m_bvalid,
   output logic                  m_bready
);

   logic [1:0]           state;
   logic [ADDR_W-1:0]    addr_q;
   logic [AXI_LEN_W-1:0] len_q;
   logic [AXI_LEN_W-1:0] beat_cnt;
   logic                 open;
   logic                 w_xfer;
   logic                 b_xfer;

   // Opening does not consume the first word
   assign open   = (state == ST_IDLE) && valid;
   assign w_xfer = m_wvalid && m_wready;
   assign b_xfer = m_bvalid && m_bready;

   assign wr_ready  = (state == ST_IDLE);
   assign m_awvalid = (state == ST_ADDR);
   assign m_awaddr  = addr_q;
   assign m_awlen   = len_q;

   // W beat follows the native word directly
   assign m_wvalid = (state == ST_DATA) && valid;
   assign m_wdata  = wdata;
   assign m_wstrb  = wstrb;
   assign m_wlast  = m_wvalid && (beat_cnt == len_q);
   assign ready    = m_wvalid && m_wready;

   // Wait for the write response
   assign m_bready = (state == ST_RESP);

   always_ff @(posedge clk) begin
      if (open) begin
         addr_q <= addr;
         len_q  <= length;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         beat_cnt <= '0;
         error    <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (open) begin
                  state    <= ST_ADDR;
                  beat_cnt <= '0;
                  error    <= 1'b0;
               end
            end
            ST_ADDR: begin
               if (m_awready) begin
                  state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (w_xfer) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (m_wlast) begin
                     state <= ST_RESP;
                  end
               end
            end
            ST_RESP: begin
               if (b_xfer) begin
                  state <= ST_IDLE;
                  if (m_bresp != RESP_OKAY) begin
                     error <= 1'b1;
                  end
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // AW request is held with stable payload until accepted
   a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
      m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr) && $stable(m_awlen));

   // W closes after the last beat and the engine waits for B
   a_no_w_after_last: assert property (@(posedge clk) disable iff (!rst_n)
      w_xfer && m_wlast |=> !m_wvalid && m_bready);

   // Beat count stays within the announced burst length
   a_beat_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      w_xfer |-> (beat_cnt <= len_q));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the bridge testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_iob2axi -f build.f &&
./obj_dir/Vtb_iob2axi | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tb_axi_mem.sv
`default_nettype none

module tb_axi_mem
   import axi_bridge_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,

   // Read channels
   input  wire  [ADDR_W-1:0]     m_araddr,
   input  wire  [AXI_LEN_W-1:0]  m_arlen,
   input  wire                   m_arvalid,
   output logic                  m_arready,
   output logic [DATA_W-1:0]     m_rdata,
   output logic [AXI_RESP_W-1:0] m_rresp,
   output logic                  m_rlast,
   output logic                  m_rvalid,
   input  wire                   m_rready,

   // Write channels
   input  wire  [ADDR_W-1:0]     m_awaddr,
   input  wire  [AXI_LEN_W-1:0]  m_awlen,
   input  wire                   m_awvalid,
   output logic                  m_awready,
   input  wire  [DATA_W-1:0]     m_wdata,
   input  wire  [DATA_W/8-1:0]   m_wstrb,
   input  wire                   m_wlast,
   input  wire                   m_wvalid,
   output logic                  m_wready,
   output logic [AXI_RESP_W-1:0] m_bresp,
   output logic                  m_bvalid,
   input  wire                   m_bready
);

   localparam int MEM_WORDS = 1024;
   localparam int IDX_W     = 10;
   localparam int ERR_BIT   = 15;
   localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'd2;

   logic [DATA_W-1:0]    mem [MEM_WORDS];
   integer               seed;

   logic                 rd_busy;
   logic [IDX_W-1:0]     rd_idx;
   logic [AXI_LEN_W-1:0] rd_len;
   logic [AXI_LEN_W-1:0] rd_cnt;
   logic                 rd_err;
   logic                 r_fire;
   logic                 wr_busy;
   logic                 wr_done;
   logic [IDX_W-1:0]     wr_idx;
   logic [AXI_LEN_W-1:0] wr_len;
   logic [AXI_LEN_W-1:0] wr_cnt;
   logic                 wr_err;

   initial begin
      seed = 25376;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = {~i[15:0], i[15:0]};
      end
   end

   // Three out of four cycles ready or valid
   function automatic logic coin();
      coin = ($random(seed) & 3) != 0;
   endfunction

   // Handshakes are taken on the rising edge
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_busy <= 1'b0;
         rd_idx  <= '0;
         rd_len  <= '0;
         rd_cnt  <= '0;
         rd_err  <= 1'b0;
         r_fire  <= 1'b0;
         wr_busy <= 1'b0;
         wr_done <= 1'b0;
         wr_idx  <= '0;
         wr_len  <= '0;
         wr_cnt  <= '0;
         wr_err  <= 1'b0;
      end else begin
         r_fire <= m_rvalid && m_rready;
         if (m_arvalid && m_arready) begin
            rd_busy <= 1'b1;
            rd_idx  <= m_araddr[IDX_W+1:2];
            rd_len  <= m_arlen;
            rd_cnt  <= '0;
            rd_err  <= m_araddr[ERR_BIT];
         end else if (m_rvalid && m_rready) begin
            rd_idx <= rd_idx + 1'b1;
            rd_cnt <= rd_cnt + 1'b1;
            if (m_rlast) begin
               rd_busy <= 1'b0;
            end
         end
         if (m_awvalid && m_awready) begin
            wr_busy <= 1'b1;
            wr_done <= 1'b0;
            wr_idx  <= m_awaddr[IDX_W+1:2];
            wr_len  <= m_awlen;
            wr_cnt  <= '0;
            wr_err  <= m_awaddr[ERR_BIT];
         end else if (m_wvalid && m_wready) begin
            wr_idx <= wr_idx + 1'b1;
            wr_cnt <= wr_cnt + 1'b1;
            // A wlast off the announced length is answered with SLVERR
            if (m_wlast != (wr_cnt == wr_len)) begin
               wr_err <= 1'b1;
            end
            if (m_wlast) begin
               wr_done <= 1'b1;
            end
         end else if (m_bvalid && m_bready) begin
            wr_busy <= 1'b0;
            wr_done <= 1'b0;
         end
      end
   end

   // Failed bursts leave memory untouched
   always @(posedge clk) begin
      if (wr_busy && !wr_err && m_wvalid && m_wready) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (m_wstrb[b]) begin
               mem[wr_idx][8*b +: 8] <= m_wdata[8*b +: 8];
            end
         end
      end
   end

   // Outputs change on the falling edge
   always @(negedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_arready <= 1'b0;
         m_rvalid  <= 1'b0;
         m_rdata   <= '0;
         m_rresp   <= RESP_OKAY;
         m_rlast   <= 1'b0;
         m_awready <= 1'b0;
         m_wready  <= 1'b0;
         m_bvalid  <= 1'b0;
         m_bresp   <= RESP_OKAY;
      end else begin
         m_arready <= !rd_busy && coin();
         if (!rd_busy) begin
            m_rvalid <= 1'b0;
         end else if (!m_rvalid || r_fire) begin
            // New beat only once the previous one was taken
            m_rvalid <= coin();
            m_rdata  <= mem[rd_idx];
            m_rlast  <= (rd_cnt == rd_len);
            m_rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
         end
         m_awready <= !wr_busy && coin();
         m_wready  <= wr_busy && !wr_done && coin();
         if (!(wr_busy && wr_done)) begin
            m_bvalid <= 1'b0;
         end else if (!m_bvalid) begin
            m_bvalid <= coin();
            m_bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_iob2axi.sv
`default_nettype none

module tb_iob2axi
   import axi_bridge_pkg::*;
();

   localparam int TIMEOUT = 2000;

   logic                  clk;
   logic                  rst_n;
   logic [AXI_LEN_W-1:0]  length;
   logic                  iob2axi_ready;
   logic                  error;
   logic                  valid;
   logic [ADDR_W-1:0]     addr;
   logic [DATA_W-1:0]     wdata;
   logic [DATA_W/8-1:0]   wstrb;
   logic [DATA_W-1:0]     rdata;
   logic                  ready;

   // AXI between bridge and memory model
   logic [ADDR_W-1:0]     m_araddr;
   logic [AXI_LEN_W-1:0]  m_arlen;
   logic                  m_arvalid;
   logic                  m_arready;
   logic [DATA_W-1:0]     m_rdata;
   logic [AXI_RESP_W-1:0] m_rresp;
   logic                  m_rlast;
   logic                  m_rvalid;
   logic                  m_rready;
   logic [ADDR_W-1:0]     m_awaddr;
   logic [AXI_LEN_W-1:0]  m_awlen;
   logic                  m_awvalid;
   logic                  m_awready;
   logic [DATA_W-1:0]     m_wdata;
   logic [DATA_W/8-1:0]   m_wstrb;
   logic                  m_wlast;
   logic                  m_wvalid;
   logic                  m_wready;
   logic [AXI_RESP_W-1:0] m_bresp;
   logic                  m_bvalid;
   logic                  m_bready;

   int pass_cnt;
   int fail_cnt;
   int check_errs;
   int burst_no;
   int beat_total;
   bit timed_out;

   iob2axi u_iob2axi (.*);

   tb_axi_mem u_mem (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Every AXI data beat on R or W
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_total <= 0;
      end else if ((m_rvalid && m_rready) || (m_wvalid && m_wready)) begin
         beat_total <= beat_total + 1;
      end
   end

   task automatic report_test(input string name, input int errs_before);
      if (check_errs == errs_before && !timed_out) begin
         pass_cnt++;
         $display("%s: ok", name);
      end else begin
         fail_cnt++;
         $display("%s: failed", name);
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (!iob2axi_ready && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (!iob2axi_ready) begin
         $display("Timeout: the bridge did not return to idle in burst %0d", burst_no);
         timed_out = 1'b1;
      end
   endtask

   task automatic check_idle_after_reset();
      int errs_before;
      errs_before = check_errs;
      repeat (4) begin
         @(posedge clk);
         assert (iob2axi_ready === 1'b1) else begin
            $display("ERROR reset: iob2axi_ready expected %h got %h", 1'b1, iob2axi_ready);
            check_errs++;
         end
         assert (error === 1'b0) else begin
            $display("ERROR reset: error expected %h got %h", 1'b0, error);
            check_errs++;
         end
      end
      report_test("reset idle", errs_before);
   endtask

   task automatic run_burst(input logic [7:0] op, input logic [ADDR_W-1:0] start,
                            input logic [AXI_LEN_W-1:0] len, input logic [DATA_W-1:0] dseed,
                            input logic [DATA_W-1:0] step, input logic exp_err);
      int errs_before;
      int beats_before;
      int last;
      int beat;
      int n;
      logic [DATA_W-1:0] expected;
      errs_before = check_errs;
      last = int'(len);
      wait_idle();
      if (!timed_out) begin
         @(negedge clk);
         beats_before = beat_total;
         length = len;
         addr   = start;
         wstrb  = (op == "W") ? '1 : '0;
         wdata  = dseed;
         valid  = 1'b1;
         beat   = 0;
         while (beat <= last && !timed_out) begin
            n = 0;
            @(posedge clk);
            while (!ready && n < TIMEOUT) begin
               @(posedge clk);
               n++;
            end
            if (!ready) begin
               $display("Timeout: burst %0d got no native ready for beat %0d", burst_no, beat);
               timed_out = 1'b1;
            end else begin
               expected = dseed + step * beat;
               assert (!iob2axi_ready) else begin
                  $display("ERROR burst %0d: iob2axi_ready expected %h got %h",
                           burst_no, 1'b0, iob2axi_ready);
                  check_errs++;
               end
               if (op == "R" && !exp_err) begin
                  assert (rdata == expected) else begin
                     $display("ERROR burst %0d beat %0d: rdata expected %h got %h",
                              burst_no, beat, expected, rdata);
                     check_errs++;
                  end
               end
               beat++;
               @(negedge clk);
               if (beat > last) begin
                  valid = 1'b0;
                  wstrb = '0;
               end else begin
                  wdata = dseed + step * beat;
               end
            end
         end
         if (!timed_out) begin
            wait_idle();
         end
         if (!timed_out) begin
            @(negedge clk);
            // Exactly one AXI data beat per native word
            assert (beat_total - beats_before == last + 1) else begin
               $display("ERROR burst %0d: AXI data beats expected %h got %h",
                        burst_no, last + 1, beat_total - beats_before);
               check_errs++;
            end
            assert (error == exp_err) else begin
               $display("ERROR burst %0d: error expected %h got %h", burst_no, exp_err, error);
               check_errs++;
            end
         end
      end
      report_test($sformatf("burst %0d %c addr %h len %0d", burst_no, op, start, last),
                  errs_before);
   endtask

   initial begin
      int fd;
      string line;
      logic [7:0]  op;
      logic [31:0] v_addr;
      logic [31:0] v_len;
      logic [31:0] v_seed;
      logic [31:0] v_step;
      logic [31:0] v_err;
      rst_n  = 1'b0;
      valid  = 1'b0;
      addr   = '0;
      wdata  = '0;
      wstrb  = '0;
      length = '0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      check_errs = 0;
      burst_no   = 0;
      timed_out  = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_idle_after_reset();
      fd = $fopen("iob2axi_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file iob2axi_vectors.txt");
         fail_cnt++;
      end else begin
         while (!timed_out && $fgets(line, fd) != 0) begin
            // Comment and blank lines do not parse into six fields
            if ($sscanf(line, "%c %h %h %h %h %h", op, v_addr, v_len, v_seed, v_step,
                        v_err) == 6) begin
               burst_no++;
               run_burst(op, v_addr, v_len[AXI_LEN_W-1:0], v_seed, v_step, v_err[0]);
            end
         end
         $fclose(fd);
      end
      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && !timed_out && burst_no > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
